// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_contract_observer -f sim.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
	exit 0
else
	exit 1
fi

// File: sim.f
src/contract_pkg.sv
src/retire_tracker.sv
src/retire_counter.sv
src/insn_classifier.sv
src/operand_observer.sv
src/hazard_history.sv
src/contract_observer.sv
sim/tb_contract_observer.sv

// File: sim/tb_contract_observer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_contract_observer;

	localparam int N_CYCLES = 3000;
	localparam int RESET_CYCLES = 8;
	localparam int DRAIN_CYCLES = 4;

	logic clock;
	logic reset;
	contract_pkg::exe_stage_t exe;
	contract_pkg::trace_rec_t rec;
	contract_pkg::insn_class_e cls;
	contract_pkg::operand_atoms_t ops;
	contract_pkg::hazard_atoms_t haz;

	integer seed;

	// Reference model state
	logic m_full;
	logic m_valid;
	contract_pkg::order_t m_count;
	contract_pkg::order_t m_order;
	contract_pkg::insn_t m_insn;
	contract_pkg::word_t m_rs1;
	contract_pkg::word_t m_rs2;
	contract_pkg::word_t m_rd;
	contract_pkg::word_t m_addr;
	contract_pkg::reg_idx_t m_hist [0:3];

	contract_observer #(
		.HISTORY_DEPTH (4)
	) i_dut (
		.clock (clock),
		.reset (reset),
		.exe_i (exe),
		.rec_o (rec),
		.class_o (cls),
		.operands_o (ops),
		.hazards_o (haz)
	);

	always #2 clock = ~clock;

	// Expected class from opcode, funct3, funct7
	function automatic contract_pkg::insn_class_e model_class(input contract_pkg::insn_t w);
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		contract_pkg::insn_class_e c;
		op = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		c = contract_pkg::CLS_OTHER;
		if (op == 7'h37) c = contract_pkg::CLS_LUI;
		else if (op == 7'h17) c = contract_pkg::CLS_AUIPC;
		else if (op == 7'h6f) c = contract_pkg::CLS_JAL;
		else if (op == 7'h67 && f3 == 3'd0) c = contract_pkg::CLS_JALR;
		else if (op == 7'h63) begin
			if (f3 == 3'd0) c = contract_pkg::CLS_BEQ;
			else if (f3 == 3'd1) c = contract_pkg::CLS_BNE;
			else if (f3 >= 3'd4) c = contract_pkg::insn_class_e'(int'(contract_pkg::CLS_BLT) + f3 - 4);
		end else if (op == 7'h03) begin
			if (f3 <= 3'd2) c = contract_pkg::insn_class_e'(int'(contract_pkg::CLS_LB) + f3);
			else if (f3 == 3'd4 || f3 == 3'd5)
				c = contract_pkg::insn_class_e'(int'(contract_pkg::CLS_LBU) + f3 - 4);
		end else if (op == 7'h23) begin
			if (f3 <= 3'd2) c = contract_pkg::insn_class_e'(int'(contract_pkg::CLS_SB) + f3);
		end else if (op == 7'h13) begin
			case (f3)
				3'd0: c = contract_pkg::CLS_ADDI;
				3'd2: c = contract_pkg::CLS_SLTI;
				3'd3: c = contract_pkg::CLS_SLTIU;
				3'd4: c = contract_pkg::CLS_XORI;
				3'd6: c = contract_pkg::CLS_ORI;
				3'd7: c = contract_pkg::CLS_ANDI;
				3'd1: if (f7 == 7'h00) c = contract_pkg::CLS_SLLI;
				default: begin
					if (f7 == 7'h00) c = contract_pkg::CLS_SRLI;
					else if (f7 == 7'h20) c = contract_pkg::CLS_SRAI;
				end
			endcase
		end else if (op == 7'h33) begin
			// M extension classes run in funct3 order
			if (f7 == 7'h01) c = contract_pkg::insn_class_e'(int'(contract_pkg::CLS_MUL) + f3);
			else if (f7 == 7'h20 && f3 == 3'd0) c = contract_pkg::CLS_SUB;
			else if (f7 == 7'h20 && f3 == 3'd5) c = contract_pkg::CLS_SRA;
			else if (f7 == 7'h00) begin
				case (f3)
					3'd0: c = contract_pkg::CLS_ADD;
					3'd1: c = contract_pkg::CLS_SLL;
					3'd2: c = contract_pkg::CLS_SLT;
					3'd3: c = contract_pkg::CLS_SLTU;
					3'd4: c = contract_pkg::CLS_XOR;
					3'd5: c = contract_pkg::CLS_SRL;
					3'd6: c = contract_pkg::CLS_OR;
					default: c = contract_pkg::CLS_AND;
				endcase
			end
		end
		return c;
	endfunction

	// Scans down from the top bit
	function automatic int model_bitlen(input contract_pkg::word_t v);
		int len;
		len = 0;
		for (int i = 31; i >= 0; i--) begin
			if (v[i] && len == 0) len = i + 1;
		end
		return len;
	endfunction

	function automatic logic model_taken(input contract_pkg::insn_class_e c,
			input contract_pkg::word_t a, input contract_pkg::word_t b);
		case (c)
			contract_pkg::CLS_JAL, contract_pkg::CLS_JALR: return 1'b1;
			contract_pkg::CLS_BEQ: return a == b;
			contract_pkg::CLS_BNE: return a != b;
			contract_pkg::CLS_BLT: return $signed(a) < $signed(b);
			contract_pkg::CLS_BGE: return $signed(a) >= $signed(b);
			contract_pkg::CLS_BLTU: return a < b;
			contract_pkg::CLS_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// Opcode and funct7 biased toward legal encodings
	function automatic contract_pkg::insn_t random_insn();
		contract_pkg::insn_t w;
		int sel;
		w = $random(seed);
		sel = $unsigned($random(seed)) % 11;
		case (sel)
			0: w[6:0] = 7'h37;
			1: w[6:0] = 7'h17;
			2: w[6:0] = 7'h6f;
			3: w[6:0] = 7'h67;
			4: w[6:0] = 7'h63;
			5: w[6:0] = 7'h03;
			6: w[6:0] = 7'h23;
			7: w[6:0] = 7'h13;
			8: w[6:0] = 7'h33;
			default: ;
		endcase
		sel = $unsigned($random(seed)) % 4;
		if (sel == 0) w[31:25] = 7'h00;
		else if (sel == 1) w[31:25] = 7'h20;
		else if (sel == 2) w[31:25] = 7'h01;
		// Small register set so hazards hit often
		if ($random(seed) & 1) begin
			w[24:22] = 3'd0;
			w[19:17] = 3'd0;
			w[11:9] = 3'd0;
		end
		return w;
	endfunction

	function automatic contract_pkg::word_t random_operand();
		case ($unsigned($random(seed)) % 6)
			0: return 32'h0;
			1: return 32'h1 << ($unsigned($random(seed)) % 32);
			2: return 32'h8000_0000;
			3: return 32'hffff_ffff;
			default: return $random(seed);
		endcase
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("ERROR time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	// Model sees the inputs of the cycle that is ending
	always @(posedge clock) begin
		if (reset) begin
			m_full = 1'b0;
			m_valid = 1'b0;
			m_count = '0;
			for (int k = 0; k < 4; k++) m_hist[k] = '0;
		end else begin
			if (m_valid) begin
				for (int k = 3; k > 0; k--) m_hist[k] = m_hist[k-1];
				m_hist[0] = m_insn[11:7];
			end
			m_valid = m_full && !exe.stall;
			if (m_valid) begin
				m_order = m_count;
				m_count = m_count + 1;
				m_insn = exe.insn;
				m_rs1 = exe.rs1_rdata;
				m_rs2 = exe.rs2_rdata;
				m_rd = exe.rd_wdata;
				m_addr = exe.mem_addr;
			end
			if (!exe.stall) m_full = !exe.if_kill;
		end
	end

	// Outputs settled mid cycle
	always @(negedge clock) begin
		contract_pkg::insn_class_e ec;
		if (!reset) begin
			check_val("rec_o.valid", rec.valid, m_valid);
			if (m_valid) begin
				ec = model_class(m_insn);
				check_val("rec_o.order", rec.order, m_order);
				check_val("rec_o.insn", rec.insn, m_insn);
				check_val("rec_o.rs1_rdata", rec.rs1_rdata, m_rs1);
				check_val("rec_o.rs2_rdata", rec.rs2_rdata, m_rs2);
				check_val("rec_o.rd_wdata", rec.rd_wdata, m_rd);
				check_val("rec_o.mem_addr", rec.mem_addr, m_addr);
				check_val("class_o", cls, ec);
				check_val("operands_o.rs1_zero", ops.rs1_zero, m_rs1 == 0);
				check_val("operands_o.rs2_zero", ops.rs2_zero, m_rs2 == 0);
				check_val("operands_o.rd_zero", ops.rd_zero, m_rd == 0);
				check_val("operands_o.rs1_bitlen", ops.rs1_bitlen, model_bitlen(m_rs1));
				check_val("operands_o.rs2_bitlen", ops.rs2_bitlen, model_bitlen(m_rs2));
				check_val("operands_o.rd_bitlen", ops.rd_bitlen, model_bitlen(m_rd));
				check_val("operands_o.word_aligned", ops.word_aligned, m_addr[1:0] == 2'd0);
				check_val("operands_o.half_aligned", ops.half_aligned, !m_addr[0] || !m_addr[1]);
				check_val("operands_o.branch_taken", ops.branch_taken, model_taken(ec, m_rs1, m_rs2));
				for (int k = 0; k < 4; k++) begin
					check_val($sformatf("hazards_o.raw_rs1[%0d]", k), haz.raw_rs1[k],
						m_insn[19:15] == m_hist[k]);
					check_val($sformatf("hazards_o.raw_rs2[%0d]", k), haz.raw_rs2[k],
						m_insn[24:20] == m_hist[k]);
					check_val($sformatf("hazards_o.waw[%0d]", k), haz.waw[k],
						m_insn[11:7] == m_hist[k]);
				end
			end
		end
	end

	initial begin
		contract_pkg::word_t rs1_val;
		seed = 32'h9afa_08a7;
		clock = 1'b0;
		reset = 1'b1;
		exe = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (int n = 0; n < N_CYCLES; n++) begin
			@(posedge clock);
			exe.insn <= random_insn();
			rs1_val = random_operand();
			exe.rs1_rdata <= rs1_val;
			// Equal operands now and then for branch edges
			if (($random(seed) & 7) == 0) exe.rs2_rdata <= rs1_val;
			else exe.rs2_rdata <= random_operand();
			exe.rd_wdata <= random_operand();
			exe.mem_addr <= $random(seed);
			exe.stall <= ($unsigned($random(seed)) % 4) == 0;
			exe.if_kill <= ($unsigned($random(seed)) % 5) == 0;
		end
		// Drain the stage
		@(posedge clock);
		exe.stall <= 1'b0;
		exe.if_kill <= 1'b1;
		repeat (DRAIN_CYCLES) @(posedge clock);
		$display("*** TEST PASSED ***");
		$finish;
	end

	// Watchdog
	initial begin
		#((RESET_CYCLES + N_CYCLES + DRAIN_CYCLES + 100) * 4);
		$display("Timeout: the run did not finish in the expected time");
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: src/contract_observer.sv
`timescale 1ns/1ps
`default_nettype none

module contract_observer #(
	// Earlier retirements checked for RAW and WAW
	parameter int HISTORY_DEPTH = 4
) (
	input wire logic clock,
	input wire logic reset,
	input contract_pkg::exe_stage_t exe_i,
	output contract_pkg::trace_rec_t rec_o,
	output contract_pkg::insn_class_e class_o,
	output contract_pkg::operand_atoms_t operands_o,
	output contract_pkg::hazard_atoms_t hazards_o
);

	// Retire strobe and its order number
	logic retire;
	contract_pkg::order_t order;
	// Register indices of the current record
	contract_pkg::reg_fields_t regs;

	// Occupancy and record capture
	retire_tracker i_retire_tracker (
		.clock_i (clock),
		.reset_i (reset),
		.exe_i (exe_i),
		.order_i (order),
		.retire_o (retire),
		.rec_o (rec_o)
	);

	retire_counter i_retire_counter (
		.clock_i (clock),
		.reset_i (reset),
		.retire_i (retire),
		.order_o (order)
	);

	// Atoms below are combinational on the record
	insn_classifier i_insn_classifier (
		.insn_i (rec_o.insn),
		.class_o (class_o),
		.regs_o (regs)
	);

	operand_observer i_operand_observer (
		.class_i (class_o),
		.rec_i (rec_o),
		.atoms_o (operands_o)
	);

	// History advances on each valid record
	hazard_history #(
		.HISTORY_DEPTH (HISTORY_DEPTH)
	) i_hazard_history (
		.clock_i (clock),
		.reset_i (reset),
		.valid_i (rec_o.valid),
		.regs_i (regs),
		.hazards_o (hazards_o)
	);

endmodule

`default_nettype wire

// File: src/contract_pkg.sv
`default_nettype none

package contract_pkg;

	// Data path widths
	localparam int XLEN = 32;
	// Upper bound on hazard history slots carried in the record
	localparam int HIST_SLOTS = 4;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0] insn_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [63:0] order_t;
	// Significant bit count, 0 up to XLEN
	typedef logic [5:0] bitlen_t;

	// Major opcodes, RV32IM
	localparam logic [6:0] OPC_LUI = 7'h37;
	localparam logic [6:0] OPC_AUIPC = 7'h17;
	localparam logic [6:0] OPC_JAL = 7'h6f;
	localparam logic [6:0] OPC_JALR = 7'h67;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_LOAD = 7'h03;
	localparam logic [6:0] OPC_STORE = 7'h23;
	localparam logic [6:0] OPC_OP_IMM = 7'h13;
	localparam logic [6:0] OPC_OP = 7'h33;

	// funct7 patterns
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	typedef enum logic [5:0] {
		CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
		CLS_BEQ, CLS_BNE, CLS_BLT, CLS_BGE, CLS_BLTU, CLS_BGEU,
		CLS_LB, CLS_LH, CLS_LW, CLS_LBU, CLS_LHU,
		CLS_SB, CLS_SH, CLS_SW,
		CLS_ADDI, CLS_SLTI, CLS_SLTIU, CLS_XORI, CLS_ORI, CLS_ANDI,
		CLS_SLLI, CLS_SRLI, CLS_SRAI,
		CLS_ADD, CLS_SUB, CLS_SLL, CLS_SLT, CLS_SLTU,
		CLS_XOR, CLS_SRL, CLS_SRA, CLS_OR, CLS_AND,
		CLS_MUL, CLS_MULH, CLS_MULHSU, CLS_MULHU,
		CLS_DIV, CLS_DIVU, CLS_REM, CLS_REMU,
		CLS_OTHER
	} insn_class_e;

	// Execute stage occupancy
	typedef enum logic {
		EXE_EMPTY,
		EXE_FULL
	} tracker_state_e;

	// Execute stage inputs, sampled every cycle
	typedef struct packed {
		logic stall;
		logic if_kill;
		insn_t insn;
		word_t rs1_rdata;
		word_t rs2_rdata;
		word_t rd_wdata;
		word_t mem_addr;
	} exe_stage_t;

	// One retired instruction
	typedef struct packed {
		logic valid;
		order_t order;
		insn_t insn;
		word_t rs1_rdata;
		word_t rs2_rdata;
		word_t rd_wdata;
		word_t mem_addr;
	} trace_rec_t;

	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
	} reg_fields_t;

	typedef struct packed {
		logic rs1_zero;
		logic rs2_zero;
		logic rd_zero;
		bitlen_t rs1_bitlen;
		bitlen_t rs2_bitlen;
		bitlen_t rd_bitlen;
		logic word_aligned;
		logic half_aligned;
		logic branch_taken;
	} operand_atoms_t;

	// Bit 0 is the most recent earlier retirement
	typedef struct packed {
		logic [HIST_SLOTS-1:0] raw_rs1;
		logic [HIST_SLOTS-1:0] raw_rs2;
		logic [HIST_SLOTS-1:0] waw;
	} hazard_atoms_t;

endpackage

`default_nettype wire

// File: src/hazard_history.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_history #(
	// At most contract_pkg::HIST_SLOTS
	parameter int HISTORY_DEPTH = 4
) (
	input wire logic clock_i,
	input wire logic reset_i,
	input wire logic valid_i,
	input contract_pkg::reg_fields_t regs_i,
	output contract_pkg::hazard_atoms_t hazards_o
);

	// Slot 0 holds the newest earlier destination
	contract_pkg::reg_idx_t hist_q [0:HISTORY_DEPTH-1];

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			// Empty history reads as x0
			for (int k = 0; k < HISTORY_DEPTH; k++) begin
				hist_q[k] <= '0;
			end
		end else if (valid_i) begin
			// Shift once the current record has been compared
			hist_q[0] <= regs_i.rd;
			for (int k = 1; k < HISTORY_DEPTH; k++) begin
				hist_q[k] <= hist_q[k-1];
			end
		end
	end

	for (genvar k = 0; k < contract_pkg::HIST_SLOTS; k++) begin : g_slot
		if (k < HISTORY_DEPTH) begin : g_used
			// Source or destination matches an earlier destination
			assign hazards_o.raw_rs1[k] = (regs_i.rs1 == hist_q[k]);
			assign hazards_o.raw_rs2[k] = (regs_i.rs2 == hist_q[k]);
			assign hazards_o.waw[k] = (regs_i.rd == hist_q[k]);
		end else begin : g_unused
			// Slots past the configured depth never flag
			assign hazards_o.raw_rs1[k] = 1'b0;
			assign hazards_o.raw_rs2[k] = 1'b0;
			assign hazards_o.waw[k] = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/insn_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module insn_classifier (
	input contract_pkg::insn_t insn_i,
	output contract_pkg::insn_class_e class_o,
	output contract_pkg::reg_fields_t regs_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];
	assign funct7 = insn_i[31:25];

	// Index fields taken at fixed positions for every format
	assign regs_o.rs1 = insn_i[19:15];
	assign regs_o.rs2 = insn_i[24:20];
	assign regs_o.rd = insn_i[11:7];

	always_comb begin
		// Anything not matched below
		class_o = contract_pkg::CLS_OTHER;
		case (opcode)
			contract_pkg::OPC_LUI: class_o = contract_pkg::CLS_LUI;
			contract_pkg::OPC_AUIPC: class_o = contract_pkg::CLS_AUIPC;
			contract_pkg::OPC_JAL: class_o = contract_pkg::CLS_JAL;
			contract_pkg::OPC_JALR: begin
				if (funct3 == 3'b000) begin
					class_o = contract_pkg::CLS_JALR;
				end
			end
			contract_pkg::OPC_BRANCH: begin
				case (funct3)
					3'b000: class_o = contract_pkg::CLS_BEQ;
					3'b001: class_o = contract_pkg::CLS_BNE;
					3'b100: class_o = contract_pkg::CLS_BLT;
					3'b101: class_o = contract_pkg::CLS_BGE;
					3'b110: class_o = contract_pkg::CLS_BLTU;
					3'b111: class_o = contract_pkg::CLS_BGEU;
					default: class_o = contract_pkg::CLS_OTHER;
				endcase
			end
			contract_pkg::OPC_LOAD: begin
				case (funct3)
					3'b000: class_o = contract_pkg::CLS_LB;
					3'b001: class_o = contract_pkg::CLS_LH;
					3'b010: class_o = contract_pkg::CLS_LW;
					3'b100: class_o = contract_pkg::CLS_LBU;
					3'b101: class_o = contract_pkg::CLS_LHU;
					default: class_o = contract_pkg::CLS_OTHER;
				endcase
			end
			contract_pkg::OPC_STORE: begin
				case (funct3)
					3'b000: class_o = contract_pkg::CLS_SB;
					3'b001: class_o = contract_pkg::CLS_SH;
					3'b010: class_o = contract_pkg::CLS_SW;
					default: class_o = contract_pkg::CLS_OTHER;
				endcase
			end
			contract_pkg::OPC_OP_IMM: begin
				case (funct3)
					3'b000: class_o = contract_pkg::CLS_ADDI;
					3'b010: class_o = contract_pkg::CLS_SLTI;
					3'b011: class_o = contract_pkg::CLS_SLTIU;
					3'b100: class_o = contract_pkg::CLS_XORI;
					3'b110: class_o = contract_pkg::CLS_ORI;
					3'b111: class_o = contract_pkg::CLS_ANDI;
					// Shift immediates need a valid funct7
					3'b001: begin
						if (funct7 == contract_pkg::F7_BASE) begin
							class_o = contract_pkg::CLS_SLLI;
						end
					end
					default: begin
						if (funct7 == contract_pkg::F7_BASE) begin
							class_o = contract_pkg::CLS_SRLI;
						end else if (funct7 == contract_pkg::F7_ALT) begin
							class_o = contract_pkg::CLS_SRAI;
						end
					end
				endcase
			end
			contract_pkg::OPC_OP: begin
				if (funct7 == contract_pkg::F7_BASE) begin
					case (funct3)
						3'b000: class_o = contract_pkg::CLS_ADD;
						3'b001: class_o = contract_pkg::CLS_SLL;
						3'b010: class_o = contract_pkg::CLS_SLT;
						3'b011: class_o = contract_pkg::CLS_SLTU;
						3'b100: class_o = contract_pkg::CLS_XOR;
						3'b101: class_o = contract_pkg::CLS_SRL;
						3'b110: class_o = contract_pkg::CLS_OR;
						default: class_o = contract_pkg::CLS_AND;
					endcase
				end else if (funct7 == contract_pkg::F7_ALT) begin
					// Only SUB and SRA use the alternate pattern
					if (funct3 == 3'b000) begin
						class_o = contract_pkg::CLS_SUB;
					end else if (funct3 == 3'b101) begin
						class_o = contract_pkg::CLS_SRA;
					end
				end else if (funct7 == contract_pkg::F7_MULDIV) begin
					case (funct3)
						3'b000: class_o = contract_pkg::CLS_MUL;
						3'b001: class_o = contract_pkg::CLS_MULH;
						3'b010: class_o = contract_pkg::CLS_MULHSU;
						3'b011: class_o = contract_pkg::CLS_MULHU;
						3'b100: class_o = contract_pkg::CLS_DIV;
						3'b101: class_o = contract_pkg::CLS_DIVU;
						3'b110: class_o = contract_pkg::CLS_REM;
						default: class_o = contract_pkg::CLS_REMU;
					endcase
				end
			end
			default: class_o = contract_pkg::CLS_OTHER;
		endcase
	end

endmodule

`default_nettype wire

// File: src/operand_observer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_observer (
	input contract_pkg::insn_class_e class_i,
	input contract_pkg::trace_rec_t rec_i,
	output contract_pkg::operand_atoms_t atoms_o
);

	logic equal;
	logic less_signed;
	logic less_unsigned;

	// Position of highest set bit plus one, zero for zero
	function automatic contract_pkg::bitlen_t bit_length(input contract_pkg::word_t value);
		contract_pkg::bitlen_t len;
		len = '0;
		for (int i = 0; i < contract_pkg::XLEN; i++) begin
			if (value[i]) begin
				len = contract_pkg::bitlen_t'(i + 1);
			end
		end
		return len;
	endfunction

	// Zero flags
	assign atoms_o.rs1_zero = (rec_i.rs1_rdata == '0);
	assign atoms_o.rs2_zero = (rec_i.rs2_rdata == '0);
	assign atoms_o.rd_zero = (rec_i.rd_wdata == '0);

	// Magnitude of each data value
	assign atoms_o.rs1_bitlen = bit_length(rec_i.rs1_rdata);
	assign atoms_o.rs2_bitlen = bit_length(rec_i.rs2_rdata);
	assign atoms_o.rd_bitlen = bit_length(rec_i.rd_wdata);

	// Address alignment
	assign atoms_o.word_aligned = (rec_i.mem_addr[1:0] == 2'b00);
	// Halfword fits unless the address is at byte 3
	assign atoms_o.half_aligned = (rec_i.mem_addr[1:0] != 2'b11);

	// Shared comparators for all six branch conditions
	assign equal = (rec_i.rs1_rdata == rec_i.rs2_rdata);
	assign less_signed = ($signed(rec_i.rs1_rdata) < $signed(rec_i.rs2_rdata));
	assign less_unsigned = (rec_i.rs1_rdata < rec_i.rs2_rdata);

	always_comb begin
		case (class_i)
			// Jumps always redirect
			contract_pkg::CLS_JAL,
			contract_pkg::CLS_JALR: atoms_o.branch_taken = 1'b1;
			contract_pkg::CLS_BEQ: atoms_o.branch_taken = equal;
			contract_pkg::CLS_BNE: atoms_o.branch_taken = !equal;
			contract_pkg::CLS_BLT: atoms_o.branch_taken = less_signed;
			contract_pkg::CLS_BGE: atoms_o.branch_taken = !less_signed;
			contract_pkg::CLS_BLTU: atoms_o.branch_taken = less_unsigned;
			contract_pkg::CLS_BGEU: atoms_o.branch_taken = !less_unsigned;
			// No control transfer
			default: atoms_o.branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/retire_counter.sv
`timescale 1ns/1ps
`default_nettype none

module retire_counter (
	input wire logic clock_i,
	input wire logic reset_i,
	input wire logic retire_i,
	output contract_pkg::order_t order_o
);

	contract_pkg::order_t count_q;

	// Counts retirements already done
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			count_q <= '0;
		end else if (retire_i) begin
			count_q <= count_q + contract_pkg::order_t'(1);
		end
	end

	// Sampled by the tracker before the increment lands
	assign order_o = count_q;

endmodule

`default_nettype wire

// File: src/retire_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module retire_tracker (
	input wire logic clock_i,
	input wire logic reset_i,
	input contract_pkg::exe_stage_t exe_i,
	input contract_pkg::order_t order_i,
	output logic retire_o,
	output contract_pkg::trace_rec_t rec_o
);

	contract_pkg::tracker_state_e state_q;
	logic valid_q;
	contract_pkg::order_t order_q;
	contract_pkg::insn_t insn_q;
	contract_pkg::word_t rs1_q;
	contract_pkg::word_t rs2_q;
	contract_pkg::word_t rd_q;
	contract_pkg::word_t addr_q;

	// Occupied slot leaves the stage when not stalled
	assign retire_o = (state_q == contract_pkg::EXE_FULL) && !exe_i.stall;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= contract_pkg::EXE_EMPTY;
			valid_q <= 1'b0;
		end else begin
			// Stall freezes occupancy, kill empties the next slot
			if (!exe_i.stall) begin
				state_q <= exe_i.if_kill ? contract_pkg::EXE_EMPTY : contract_pkg::EXE_FULL;
			end
			// Single cycle record strobe
			valid_q <= retire_o;
		end
	end

	// Payload held between retirements
	always_ff @(posedge clock_i) begin
		if (retire_o) begin
			order_q <= order_i;
			insn_q <= exe_i.insn;
			rs1_q <= exe_i.rs1_rdata;
			rs2_q <= exe_i.rs2_rdata;
			rd_q <= exe_i.rd_wdata;
			addr_q <= exe_i.mem_addr;
		end
	end

	assign rec_o = '{
		valid: valid_q,
		order: order_q,
		insn: insn_q,
		rs1_rdata: rs1_q,
		rs2_rdata: rs2_q,
		rd_wdata: rd_q,
		mem_addr: addr_q
	};

endmodule

`default_nettype wire
